/* Bender.yml */
package:
  name: eightbit_cpu

sources:
  - files:
      - verilog/cpu_pkg.sv
      - verilog/mem_port_if.sv
      - verilog/fetch_unit.sv
      - verilog/decode_unit.sv
      - verilog/exec_unit.sv
      - verilog/writeback_unit.sv
      - verilog/eightbit_cpu.sv
  - target: test
    files:
      - bench/tb_eightbit_cpu.sv

/* bench/tb_eightbit_cpu.sv */
`default_nettype none

module tb_eightbit_cpu;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period          = 40;
    localparam int program_insts       = 31;
    localparam int max_cycles_per_inst = 20;
    localparam int watchdog_ns = program_insts * max_cycles_per_inst * 8 * clk_period;

    logic       clk;
    logic       rst;
    logic       mem_ready;
    logic [7:0] mem_rdata;
    logic [7:0] mem_addr;
    logic [7:0] mem_wdata;
    logic       mem_we;
    logic       mem_req;

    logic [7:0] mem [256];
    logic [7:0] ref_mem [256];
    logic [7:0] exp_addr [64];
    logic [7:0] exp_data [64];
    int         exp_count = 0;
    int         store_idx = 0;
    int         txn_count = 0;
    int         cycle_count = 0;
    int         run_cycles = 0;
    int         prog_addr = 0;
    integer     seed = 56;

    eightbit_cpu dut0 (
        .clk       (clk),
        .rst       (rst),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_req   (mem_req)
    );

    task automatic report_failure(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic emit_imm(input logic [3:0] op, input logic [3:0] rd, input logic [7:0] imm);
        cpu_pkg::inst_word_u w;
        w.i.opcode = op;
        w.i.rd = rd;
        w.i.imm = imm;
        mem[prog_addr] = w[15:8];
        mem[prog_addr + 1] = w[7:0];
        prog_addr += 2;
    endtask

    task automatic append_reg(input logic [3:0] op, input logic [3:0] rd,
                              input logic [3:0] rs1, input logic [3:0] rs2);
        cpu_pkg::inst_word_u w;
        w.r.opcode = op;
        w.r.rd = rd;
        w.r.rs1 = rs1;
        w.r.rs2 = rs2;
        mem[prog_addr] = w[15:8];
        mem[prog_addr + 1] = w[7:0];
        prog_addr += 2;
    endtask

    task automatic load_program();
        foreach (mem[a])
            mem[a] = 8'(a) ^ 8'h5a;
        emit_imm(cpu_pkg::op_lodi, 4'd1, 8'h7f);
        emit_imm(cpu_pkg::op_lodi, 4'd2, 8'h85);
        // 0x7f + 0x85 wraps around.
        append_reg(cpu_pkg::op_add, 4'd3, 4'd1, 4'd2);
        emit_imm(cpu_pkg::op_str, 4'd3, 8'he0);
        emit_imm(cpu_pkg::op_addi, 4'd1, 8'h90);
        emit_imm(cpu_pkg::op_str, 4'd1, 8'he1);
        append_reg(cpu_pkg::op_nand, 4'd4, 4'd1, 4'd2);
        emit_imm(cpu_pkg::op_str, 4'd4, 8'he2);
        emit_imm(cpu_pkg::op_lod, 4'd5, 8'hc3);
        emit_imm(cpu_pkg::op_lod, 4'd6, 8'hc8);
        append_reg(cpu_pkg::op_add, 4'd7, 4'd5, 4'd6);
        emit_imm(cpu_pkg::op_str, 4'd7, 8'he3);
        emit_imm(cpu_pkg::op_str, 4'd5, 8'he4);
        emit_imm(cpu_pkg::op_lodi, 4'd8, 8'h00);
        // taken jump skips the store to 0xe5.
        emit_imm(cpu_pkg::op_jeqz, 4'd8, 8'd34);
        emit_imm(cpu_pkg::op_lodi, 4'd9, 8'h11);
        emit_imm(cpu_pkg::op_str, 4'd9, 8'he5);
        // not taken because r1 holds 0x0f.
        emit_imm(cpu_pkg::op_jeqz, 4'd1, 8'd40);
        emit_imm(cpu_pkg::op_lodi, 4'd9, 8'h22);
        emit_imm(cpu_pkg::op_str, 4'd9, 8'he6);
        emit_imm(cpu_pkg::op_jmp, 4'd0, 8'd46);
        emit_imm(cpu_pkg::op_lodi, 4'd10, 8'h33);
        emit_imm(cpu_pkg::op_str, 4'd10, 8'he7);
        append_reg(cpu_pkg::op_nand, 4'd11, 4'd9, 4'd9);
        emit_imm(cpu_pkg::op_str, 4'd11, 8'he8);
        // reads back the first stored result.
        emit_imm(cpu_pkg::op_lod, 4'd12, 8'he0);
        emit_imm(cpu_pkg::op_addi, 4'd12, 8'hff);
        emit_imm(cpu_pkg::op_str, 4'd12, 8'he9);
        emit_imm(cpu_pkg::op_addi, 4'd13, 8'h05);
        emit_imm(cpu_pkg::op_str, 4'd13, 8'hea);
        emit_imm(cpu_pkg::op_jmp, 4'd0, 8'd60);
        foreach (mem[a])
            ref_mem[a] = mem[a];
    endtask

    // instruction level model that runs until the jump to itself.
    task automatic run_model();
        logic [7:0]          regs [16];
        logic [7:0]          pc;
        logic [7:0]          next_pc;
        cpu_pkg::inst_word_u w;
        bit                  done;
        int                  steps;
        foreach (regs[i])
            regs[i] = '0;
        pc = '0;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 200) begin
            w = {ref_mem[pc], ref_mem[pc + 8'd1]};
            next_pc = pc + 8'd2;
            case (w.r.opcode)
                cpu_pkg::op_jmp: begin
                    done = w.i.imm == pc;
                    next_pc = w.i.imm;
                end
                cpu_pkg::op_jeqz: begin
                    if (regs[w.i.rd] == 8'd0)
                        next_pc = w.i.imm;
                end
                cpu_pkg::op_lod: regs[w.i.rd] = ref_mem[w.i.imm];
                cpu_pkg::op_str: begin
                    ref_mem[w.i.imm] = regs[w.i.rd];
                    exp_addr[exp_count] = w.i.imm;
                    exp_data[exp_count] = regs[w.i.rd];
                    exp_count++;
                end
                cpu_pkg::op_add: regs[w.r.rd] = regs[w.r.rs1] + regs[w.r.rs2];
                cpu_pkg::op_addi: regs[w.i.rd] = regs[w.i.rd] + w.i.imm;
                cpu_pkg::op_lodi: regs[w.i.rd] = w.i.imm;
                cpu_pkg::op_nand: regs[w.r.rd] = ~(regs[w.r.rs1] & regs[w.r.rs2]);
                default: ;
            endcase
            pc = next_pc;
            steps++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // memory answers after 0 to 3 cycles.
    initial begin
        int unsigned delay;
        mem_ready = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            mem_ready = 1'b0;
            if (rst && mem_req) begin
                delay = {$random(seed)} % 4;
                repeat (delay) @(negedge clk);
                if (mem_we)
                    mem[mem_addr] = mem_wdata;
                else
                    mem_rdata = mem[mem_addr];
                mem_ready = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        run_cycles <= rst ? run_cycles + 1 : 0;
        if (rst && mem_req && mem_ready)
            txn_count <= txn_count + 1;
        if (rst && mem_req && mem_we && mem_ready)
            store_idx <= store_idx + 1;
    end

    assert property (@(posedge clk)
        (cycle_count > 0 && run_cycles < 2) |-> (!mem_req && !mem_we))
        else report_failure("bus request active during or right after reset");

    assert property (@(posedge clk) disable iff (!rst)
        (mem_req && mem_ready && txn_count < 2) |->
            (!mem_we && mem_addr == 8'(txn_count)))
        else report_failure($sformatf("request %0d after reset is not a read of %0d",
                                      $sampled(txn_count), $sampled(txn_count)));

    assert property (@(posedge clk) disable iff (!rst)
        (mem_req && !mem_ready) |=>
            ($stable(mem_addr) && $stable(mem_we) && (!mem_we || $stable(mem_wdata))))
        else report_failure("bus outputs changed while a request was pending");

    assert property (@(posedge clk) disable iff (!rst)
        (mem_req && mem_we && mem_ready) |-> (store_idx < exp_count))
        else report_failure("store seen after the expected list was complete");

    assert property (@(posedge clk) disable iff (!rst)
        (mem_req && mem_we && mem_ready) |->
            (store_idx >= exp_count ||
             (mem_addr == exp_addr[store_idx] && mem_wdata == exp_data[store_idx])))
        else report_failure($sformatf("store %0d wrote %h to %h",
                                      $sampled(store_idx), $sampled(mem_wdata),
                                      $sampled(mem_addr)));

    initial begin
        #(watchdog_ns);
        $display("Timeout: only %0d of %0d stores seen after %0d ns",
                 store_idx, exp_count, watchdog_ns);
        $display("Verification failed");
        $fatal(1);
    end

    initial begin
        rst = 1'b0;
        load_program();
        run_model();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        wait (store_idx == exp_count);
        // a few more cycles so a stray store would still be caught.
        repeat (20) @(negedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
verilog/cpu_pkg.sv
verilog/mem_port_if.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/exec_unit.sv
verilog/writeback_unit.sv
verilog/eightbit_cpu.sv
bench/tb_eightbit_cpu.sv

/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int data_width = 8;
    localparam int inst_width = 16;
    localparam int reg_count  = 16;

    // opcodes, in encoding order.
    localparam logic [3:0] op_jmp  = 4'd0;
    localparam logic [3:0] op_lod  = 4'd1;
    localparam logic [3:0] op_str  = 4'd2;
    localparam logic [3:0] op_add  = 4'd3;
    localparam logic [3:0] op_addi = 4'd4;
    localparam logic [3:0] op_lodi = 4'd5;
    localparam logic [3:0] op_nand = 4'd6;
    localparam logic [3:0] op_jeqz = 4'd7;

    // three register operands.
    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] rd;
        logic [3:0] rs1;
        logic [3:0] rs2;
    } reg_form_t;

    // imm doubles as the address for jumps, loads and stores.
    typedef struct packed {
        logic [3:0]            opcode;
        logic [3:0]            rd;
        logic [data_width-1:0] imm;
    } imm_form_t;

    typedef union packed {
        reg_form_t r;
        imm_form_t i;
    } inst_word_u;

endpackage

`default_nettype wire

/* verilog/decode_unit.sv */
`default_nettype none

module decode_unit (
    input  wire                            clk,
    input  wire                            en,
    input  wire cpu_pkg::inst_word_u       inst,
    output logic [3:0]                     op,
    output logic [3:0]                     rd,
    output logic [3:0]                     rs1,
    output logic [3:0]                     rs2,
    output logic [cpu_pkg::data_width-1:0] imm,
    output logic                           rd_src,
    output logic                           ready
);

    always_ff @(posedge clk) begin
        ready <= en;
        if (en) begin
            op     <= inst.r.opcode;
            rd     <= inst.r.rd;
            rs1    <= inst.r.rs1;
            rs2    <= inst.r.rs2;
            imm    <= inst.i.imm;
            // these read rd instead of rs1 on port a.
            rd_src <= inst.r.opcode == cpu_pkg::op_str ||
                      inst.r.opcode == cpu_pkg::op_addi ||
                      inst.r.opcode == cpu_pkg::op_jeqz;
        end
    end

endmodule

`default_nettype wire

/* verilog/eightbit_cpu.sv */
`default_nettype none

module eightbit_cpu (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            mem_ready,
    input  wire [cpu_pkg::data_width-1:0]  mem_rdata,
    output logic [cpu_pkg::data_width-1:0] mem_addr,
    output logic [cpu_pkg::data_width-1:0] mem_wdata,
    output logic                           mem_we,
    output logic                           mem_req
);

    logic [cpu_pkg::data_width-1:0] pc;

    logic                           fetch_en;
    logic                           fetch_ready;
    cpu_pkg::inst_word_u            fetch_inst;

    logic                           decode_en;
    logic                           decode_ready;
    cpu_pkg::inst_word_u            decode_inst;
    logic [3:0]                     decode_op;
    logic [3:0]                     decode_rd;
    logic [3:0]                     decode_rs1;
    logic [3:0]                     decode_rs2;
    logic [cpu_pkg::data_width-1:0] decode_imm;
    logic                           decode_rd_src;

    logic                           exec_en;
    logic                           exec_ready;
    logic [3:0]                     exec_op;
    logic [3:0]                     exec_rd;
    logic [cpu_pkg::data_width-1:0] exec_val1;
    logic [cpu_pkg::data_width-1:0] exec_val2;
    logic [cpu_pkg::data_width-1:0] exec_addr;
    logic [cpu_pkg::data_width-1:0] exec_result;

    logic                           wb_en;
    logic                           wb_ready;
    logic [3:0]                     wb_op;
    logic [3:0]                     wb_rd;
    logic [3:0]                     rd_sel_a;
    logic [cpu_pkg::data_width-1:0] rd_data_a;
    logic [cpu_pkg::data_width-1:0] rd_data_b;

    logic                           fetch_busy;
    logic                           exec_grant;
    logic                           fetch_grant;
    logic [cpu_pkg::data_width-1:0] rdata_q;

    logic fetch_idle;
    logic fetch_done;
    logic decode_idle;
    logic decode_done;
    logic exec_idle;
    logic exec_done;
    logic wb_idle;
    logic wb_done;

    mem_port_if fetch_bus ();
    mem_port_if exec_bus ();

    fetch_unit fetch0 (
        .clk   (clk),
        .rst   (rst),
        .en    (fetch_en),
        .pc    (pc),
        .bus   (fetch_bus),
        .inst  (fetch_inst),
        .ready (fetch_ready)
    );

    decode_unit decode0 (
        .clk    (clk),
        .en     (decode_en),
        .inst   (decode_inst),
        .op     (decode_op),
        .rd     (decode_rd),
        .rs1    (decode_rs1),
        .rs2    (decode_rs2),
        .imm    (decode_imm),
        .rd_src (decode_rd_src),
        .ready  (decode_ready)
    );

    exec_unit exec0 (
        .clk    (clk),
        .rst    (rst),
        .en     (exec_en),
        .op     (exec_op),
        .val1   (exec_val1),
        .val2   (exec_val2),
        .addr   (exec_addr),
        .bus    (exec_bus),
        .result (exec_result),
        .ready  (exec_ready)
    );

    writeback_unit wb0 (
        .clk       (clk),
        .rst       (rst),
        .en        (wb_en),
        .op        (wb_op),
        .rd        (wb_rd),
        .val       (exec_result),
        .rd_sel_a  (rd_sel_a),
        .rd_sel_b  (decode_rs2),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .ready     (wb_ready)
    );

    assign fetch_idle  = !fetch_en && !fetch_ready;
    assign fetch_done  = fetch_en && fetch_ready;
    assign decode_idle = !decode_en && !decode_ready;
    assign decode_done = decode_en && decode_ready;
    assign exec_idle   = !exec_en && !exec_ready;
    assign exec_done   = exec_en && exec_ready;
    assign wb_idle     = !wb_en && !wb_ready;
    assign wb_done     = wb_en && wb_ready;

    assign rd_sel_a = decode_rd_src ? decode_rd : decode_rs1;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc        <= '0;
            fetch_en  <= 1'b0;
            decode_en <= 1'b0;
            exec_en   <= 1'b0;
            wb_en     <= 1'b0;
        end else begin
            if (fetch_idle)
                fetch_en <= 1'b1;
            if (fetch_done && decode_idle) begin
                decode_inst <= fetch_inst;
                decode_en   <= 1'b1;
                fetch_en    <= 1'b0;
                pc          <= pc + 2'd2;
            end
            // all older results are in the register file by now.
            if (decode_done && exec_idle && wb_idle) begin
                decode_en <= 1'b0;
                exec_op   <= decode_op;
                exec_rd   <= decode_rd;
                exec_addr <= decode_imm;
                exec_val1 <= decode_op == cpu_pkg::op_lodi ? decode_imm : rd_data_a;
                exec_val2 <= decode_op == cpu_pkg::op_addi ? decode_imm : rd_data_b;
                case (decode_op)
                    cpu_pkg::op_jmp: begin
                        pc       <= decode_imm;
                        fetch_en <= 1'b0;
                    end
                    cpu_pkg::op_jeqz: begin
                        if (rd_data_a == '0) begin
                            pc       <= decode_imm;
                            fetch_en <= 1'b0;
                        end
                    end
                    default: exec_en <= 1'b1;
                endcase
            end
            if (exec_done && wb_idle) begin
                exec_en <= 1'b0;
                wb_op   <= exec_op;
                wb_rd   <= exec_rd;
                wb_en   <= 1'b1;
            end
            if (wb_done)
                wb_en <= 1'b0;
        end
    end

    // a requester that is seeing its ready pulse is not asking again.
    assign exec_grant  = !mem_req && exec_bus.req && !exec_bus.ready;
    assign fetch_grant = !mem_req && !exec_grant && fetch_bus.req && !fetch_bus.ready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            mem_req         <= 1'b0;
            mem_we          <= 1'b0;
            fetch_busy      <= 1'b0;
            fetch_bus.ready <= 1'b0;
            exec_bus.ready  <= 1'b0;
        end else if (mem_req) begin
            if (mem_ready) begin
                mem_req         <= 1'b0;
                mem_we          <= 1'b0;
                fetch_bus.ready <= fetch_busy;
                exec_bus.ready  <= !fetch_busy;
            end
        end else begin
            fetch_bus.ready <= 1'b0;
            exec_bus.ready  <= 1'b0;
            mem_req         <= exec_grant || fetch_grant;
            mem_we          <= exec_grant && exec_bus.we;
            fetch_busy      <= fetch_grant;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_grant) begin
            mem_addr  <= exec_bus.addr;
            mem_wdata <= exec_bus.wdata;
        end else if (fetch_grant) begin
            mem_addr <= fetch_bus.addr;
        end
        if (mem_req && mem_ready)
            rdata_q <= mem_rdata;
    end

    assign fetch_bus.rdata = rdata_q;
    assign exec_bus.rdata  = rdata_q;

endmodule

`default_nettype wire

/* verilog/exec_unit.sv */
`default_nettype none

module exec_unit (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            en,
    input  wire [3:0]                      op,
    input  wire [cpu_pkg::data_width-1:0]  val1,
    input  wire [cpu_pkg::data_width-1:0]  val2,
    input  wire [cpu_pkg::data_width-1:0]  addr,
    mem_port_if.master                     bus,
    output logic [cpu_pkg::data_width-1:0] result,
    output logic                           ready
);

    always_ff @(posedge clk) begin
        if (!rst) begin
            bus.req <= 1'b0;
            bus.we  <= 1'b0;
            ready   <= 1'b0;
        end else if (!en) begin
            ready <= 1'b0;
        end else if (!ready) begin
            case (op)
                cpu_pkg::op_lod, cpu_pkg::op_str: begin
                    if (!bus.req) begin
                        bus.req   <= 1'b1;
                        bus.we    <= op == cpu_pkg::op_str;
                        bus.addr  <= addr;
                        bus.wdata <= val1;
                    end else if (bus.ready) begin
                        bus.req <= 1'b0;
                        bus.we  <= 1'b0;
                        ready   <= 1'b1;
                        if (op == cpu_pkg::op_lod)
                            result <= bus.rdata;
                    end
                end
                cpu_pkg::op_add, cpu_pkg::op_addi: begin
                    result <= val1 + val2;
                    ready  <= 1'b1;
                end
                cpu_pkg::op_nand: begin
                    result <= ~(val1 & val2);
                    ready  <= 1'b1;
                end
                cpu_pkg::op_lodi: begin
                    result <= val1;
                    ready  <= 1'b1;
                end
                default: ready <= 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_unit.sv */
`default_nettype none

module fetch_unit (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            en,
    input  wire [cpu_pkg::data_width-1:0]  pc,
    mem_port_if.reader                     bus,
    output cpu_pkg::inst_word_u            inst,
    output logic                           ready
);

    logic [cpu_pkg::data_width-1:0] hi_byte;
    logic [cpu_pkg::inst_width-1:0] word;
    logic                           hi_done;
    logic                           stale;

    assign inst = word;

    always_ff @(posedge clk) begin
        if (!rst) begin
            bus.req <= 1'b0;
            hi_done <= 1'b0;
            stale   <= 1'b0;
            ready   <= 1'b0;
        end else if (bus.req) begin
            // en fell while on the bus, so this byte is thrown away.
            if (!en)
                stale <= 1'b1;
            if (bus.ready) begin
                bus.req <= 1'b0;
                stale   <= 1'b0;
                if (!en || stale) begin
                    hi_done <= 1'b0;
                end else if (!hi_done) begin
                    hi_done <= 1'b1;
                end else begin
                    hi_done <= 1'b0;
                    ready   <= 1'b1;
                end
            end
        end else if (!en) begin
            ready   <= 1'b0;
            hi_done <= 1'b0;
        end else if (!ready) begin
            bus.req  <= 1'b1;
            bus.addr <= hi_done ? pc + 1'b1 : pc;
        end
    end

    // high byte comes first, at pc.
    always_ff @(posedge clk) begin
        if (bus.req && bus.ready) begin
            if (hi_done)
                word <= {hi_byte, bus.rdata};
            else
                hi_byte <= bus.rdata;
        end
    end

endmodule

`default_nettype wire

/* verilog/mem_port_if.sv */
`default_nettype none

interface mem_port_if;

    logic                           req;
    logic                           we;
    logic [cpu_pkg::data_width-1:0] addr;
    logic [cpu_pkg::data_width-1:0] wdata;
    logic [cpu_pkg::data_width-1:0] rdata;
    logic                           ready;

    // read-only requester.
    modport reader (output req, output addr, input rdata, input ready);

    modport master (output req, output we, output addr, output wdata,
                    input rdata, input ready);

    // arbiter side.
    modport port (input req, input we, input addr, input wdata,
                  output rdata, output ready);

endinterface

`default_nettype wire

/* verilog/writeback_unit.sv */
`default_nettype none

module writeback_unit (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            en,
    input  wire [3:0]                      op,
    input  wire [3:0]                      rd,
    input  wire [cpu_pkg::data_width-1:0]  val,
    input  wire [3:0]                      rd_sel_a,
    input  wire [3:0]                      rd_sel_b,
    output logic [cpu_pkg::data_width-1:0] rd_data_a,
    output logic [cpu_pkg::data_width-1:0] rd_data_b,
    output logic                           ready
);

    logic [cpu_pkg::data_width-1:0] regs [cpu_pkg::reg_count];
    logic                           writes_reg;

    // stores and jumps leave the register file alone.
    assign writes_reg = !(op == cpu_pkg::op_str || op == cpu_pkg::op_jmp ||
                          op == cpu_pkg::op_jeqz);

    always_ff @(posedge clk) begin
        if (!rst) begin
            ready <= 1'b0;
            for (int i = 0; i < cpu_pkg::reg_count; i++)
                regs[i] <= '0;
        end else begin
            ready <= en;
            if (en && !ready && writes_reg)
                regs[rd] <= val;
        end
    end

    assign rd_data_a = regs[rd_sel_a];
    assign rd_data_b = regs[rd_sel_b];

endmodule

`default_nettype wire
